/* verilog/tetrisPkg.sv */
package tetrisPkg;

	// decoded key codes.
	localparam logic [7:0] KeySpace = 8'h2C; // starts a game.
	localparam logic [7:0] KeyEsc = 8'h29;   // back to the wait state.
	localparam logic [7:0] KeyPause = 8'h13; // the P key.
	localparam logic [7:0] KeyTab = 8'h2B;   // hold the falling piece.

	// stack size in cells.
	localparam int BoardRows = 20;
	localparam int BoardCols = 10;

	// leftmost board column covered by the 4x4 piece box.
	localparam int SpawnCol = 3;

	// clock cycles between one-row falls.
	localparam int DropPeriod = 8;

	// generator register value after reset.
	localparam logic [15:0] LfsrSeed = 16'hACE1;

	localparam int PieceCount = 7;

	// 4x4 masks, bit 4*r+c is box row r, column c.
	localparam logic [15:0] pieceShape [PieceCount] = '{
		16'h00F0, // I.
		16'h0066, // O.
		16'h0027, // T.
		16'h0036, // S.
		16'h0063, // Z.
		16'h0071, // J.
		16'h0074  // L.
	};

	// first sprite of each piece, four sprites apart.
	localparam logic [5:0] spriteBase [PieceCount] = '{
		6'd0,
		6'd4,
		6'd8,
		6'd12,
		6'd16,
		6'd20,
		6'd24
	};

	typedef enum logic [2:0] {
		Wait,
		Drop,
		Falling,
		Hold,
		Bottom,
		PauseState1,
		PauseState2
	} gameState_t;

endpackage

/* verilog/pieceGenerator.sv */
module pieceGenerator (
	input logic Clk,
	input logic rst,
	input logic pickPiece,
	output logic [15:0] nextShape,
	output logic [5:0] nextSprite
);
	import tetrisPkg::*;

	logic [15:0] lfsr;
	logic feedback;
	logic [2:0] pieceIdx;

	// taps 16, 14, 13 and 11 of a 16-bit Fibonacci register.
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge Clk)
	begin
		if (rst)
			lfsr <= LfsrSeed;
		else if (pickPiece)
			lfsr <= {lfsr[14:0], feedback}; // shift toward the msb.
	end

	// the low three bits pick the piece and the spare code folds onto piece 0.
	always_comb
	begin
		if (int'(lfsr[2:0]) >= PieceCount)
			pieceIdx = 3'd0;
		else
			pieceIdx = lfsr[2:0];
	end

	// always shows what the next pick will hand out.
	assign nextShape = pieceShape[pieceIdx];
	assign nextSprite = spriteBase[pieceIdx];

endmodule

/* verilog/gameControl.sv */
module gameControl (
	input logic Clk,
	input logic rst,
	input logic [7:0] keycode,
	input logic hitBottom,
	input logic [15:0] nextShape,
	input logic [5:0] nextSprite,
	output logic pickPiece,
	output logic spawnPiece,
	output logic clearBoard,
	output logic falling,
	output logic pause,
	output logic [15:0] blockState,
	output logic [15:0] holdState,
	output logic [5:0] spriteIndex,
	output tetrisPkg::gameState_t state
);
	import tetrisPkg::*;

	gameState_t nextState;
	logic canHold;
	logic canHoldNext;
	logic [15:0] blockNext;
	logic [15:0] holdNext;
	logic [5:0] spriteNext;

	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			state <= Wait;
			canHold <= 1'b1;
			blockState <= '0;
			holdState <= '0;
			spriteIndex <= '0;
		end
		else
		begin
			state <= nextState;
			canHold <= canHoldNext;
			blockState <= blockNext;
			holdState <= holdNext;
			spriteIndex <= spriteNext;
		end
	end

	// next state.
	always_comb
	begin
		nextState = state;
		unique case (state)
			Wait:
				if (keycode == KeySpace)
					nextState = Drop;
			Drop:
				nextState = Falling;
			Falling:
			begin
				if (hitBottom) // landing wins over any key.
					nextState = Bottom;
				else if (keycode == KeyEsc)
					nextState = Wait;
				else if (keycode == KeyTab && canHold)
					nextState = Hold;
			end
			Hold:
				nextState = Drop;
			Bottom:
				nextState = PauseState1;
			PauseState1: // stay while P is still held down.
				if (keycode != KeyPause)
					nextState = PauseState2;
			PauseState2:
				if (keycode == KeyPause)
					nextState = Drop;
			default:
				nextState = Wait;
		endcase
	end

	// piece registers and the hold flag.
	always_comb
	begin
		canHoldNext = canHold;
		blockNext = blockState;
		holdNext = holdState;
		spriteNext = spriteIndex;
		case (state)
			Drop:
			begin
				blockNext = nextShape; // new piece from the generator.
				spriteNext = nextSprite;
			end
			Hold:
			begin
				holdNext = blockState;
				canHoldNext = 1'b0; // one hold per landed piece.
			end
			Bottom:
				canHoldNext = 1'b1;
			default:
			begin
			end
		endcase
	end

	// strobes and levels decoded from the state.
	assign pickPiece = (state == Drop);
	assign spawnPiece = (state == Drop);
	assign clearBoard = (state == Wait);
	assign falling = (state == Falling);
	assign pause = (state == Wait) || (state == PauseState1) || (state == PauseState2);

endmodule

/* verilog/playfield.sv */
module playfield (
	input logic Clk,
	input logic rst,
	input logic spawnPiece,
	input logic clearBoard,
	input logic falling,
	input logic [15:0] blockState,
	input logic [4:0] rowSel,
	output logic hitBottom,
	output logic [4:0] pieceRow,
	output logic [9:0] rowBits
);
	import tetrisPkg::*;

	logic [BoardCols-1:0] stack [BoardRows]; // bit c of a row is board column c.
	logic [$clog2(DropPeriod)-1:0] dropCount;
	logic dropTick;
	logic blocked;

	// last cycle of a drop period while the piece is falling.
	assign dropTick = falling && (int'(dropCount) == DropPeriod - 1);

	// would the piece overlap anything one row lower
	always_comb
	begin
		int below;
		blocked = 1'b0;
		for (int r = 0; r < 4; r++)
		begin
			below = int'(pieceRow) + r + 1;
			if (blockState[4*r +: 4] != 4'b0)
			begin
				if (below >= BoardRows)
					blocked = 1'b1; // past the floor.
				else if ((stack[below][SpawnCol +: 4] & blockState[4*r +: 4]) != 4'b0)
					blocked = 1'b1;
			end
		end
	end

	assign hitBottom = dropTick && blocked;

	// drop timer and falling row.
	always_ff @(posedge Clk)
	begin
		if (rst)
		begin
			dropCount <= '0;
			pieceRow <= '0;
		end
		else if (spawnPiece)
		begin
			dropCount <= '0;
			pieceRow <= '0; // new piece enters at the top.
		end
		else if (falling)
		begin
			if (dropTick)
			begin
				dropCount <= '0;
				if (!blocked)
					pieceRow <= pieceRow + 5'd1;
			end
			else
				dropCount <= dropCount + 1;
		end
	end

	// stack that is cleared as a whole or or'd with the landed piece.
	always_ff @(posedge Clk)
	begin
		if (clearBoard)
		begin
			for (int i = 0; i < BoardRows; i++)
				stack[i] <= '0;
		end
		else if (hitBottom)
		begin
			for (int r = 0; r < 4; r++)
			begin
				if (int'(pieceRow) + r < BoardRows)
					stack[pieceRow + 5'(r)][SpawnCol +: 4] <=
						stack[pieceRow + 5'(r)][SpawnCol +: 4] | blockState[4*r +: 4];
			end
		end
	end

	// rows past the bottom read as empty.
	assign rowBits = (int'(rowSel) < BoardRows) ? stack[rowSel] : '0;

endmodule

/* verilog/tetrisCore.sv */
module tetrisCore (
	input logic Clk,
	input logic rst,
	input logic [7:0] keycode,
	input logic [4:0] rowSel,
	output logic [15:0] blockState,
	output logic [15:0] holdState,
	output logic [5:0] spriteIndex,
	output logic [4:0] pieceRow,
	output logic [tetrisPkg::BoardCols-1:0] rowBits,
	output logic pause,
	output tetrisPkg::gameState_t state
);

	logic pickPiece;
	logic spawnPiece;
	logic clearBoard;
	logic falling;
	logic hitBottom;
	logic [15:0] nextShape;
	logic [5:0] nextSprite;

	pieceGenerator generator0 (
		.Clk(Clk),
		.rst(rst),
		.pickPiece(pickPiece),
		.nextShape(nextShape),
		.nextSprite(nextSprite)
	);

	gameControl control0 (
		.Clk(Clk),
		.rst(rst),
		.keycode(keycode),
		.hitBottom(hitBottom),
		.nextShape(nextShape),
		.nextSprite(nextSprite),
		.pickPiece(pickPiece),
		.spawnPiece(spawnPiece),
		.clearBoard(clearBoard),
		.falling(falling),
		.pause(pause),
		.blockState(blockState),
		.holdState(holdState),
		.spriteIndex(spriteIndex),
		.state(state)
	);

	playfield field0 (
		.Clk(Clk),
		.rst(rst),
		.spawnPiece(spawnPiece),
		.clearBoard(clearBoard),
		.falling(falling),
		.blockState(blockState),
		.rowSel(rowSel),
		.hitBottom(hitBottom),
		.pieceRow(pieceRow),
		.rowBits(rowBits)
	);

endmodule

/* testbench/tbClock.sv */
module tbClock (
	output logic Clk
);

	localparam int HalfPeriod = 50; // 100 time-unit period.

	initial
	begin
		Clk = 1'b0;
		forever
			#HalfPeriod Clk = ~Clk;
	end

endmodule

/* testbench/tetrisTb.sv */
module tetrisTb;
	import tetrisPkg::*;

	localparam int ClkPeriod = 100;
	localparam int DriveDelay = 10; // inputs change this long after the rising edge.
	localparam int WatchdogCycles = 20000; // all drop times together stay under 6000 cycles.
	localparam int PauseHoldCycles = 3;
	localparam int unsigned RandomSeed = 32'h0294c411;

	logic Clk;
	logic rst;
	logic [7:0] keycode;
	logic [4:0] rowSel;
	logic [15:0] blockState;
	logic [15:0] holdState;
	logic [5:0] spriteIndex;
	logic [4:0] pieceRow;
	logic [BoardCols-1:0] rowBits;
	logic pause;
	gameState_t state;

	logic [15:0] modelLfsr; // mirror of the piece generator register.
	logic [15:0] curShape; // shape of the piece the core should be dropping.
	logic [BoardCols-1:0] modelStack [BoardRows];
	gameState_t prevState;
	int fallCycles; // cycles spent in Falling by the current piece.
	logic [7:0] idleKey;

	tbClock clock0 (
		.Clk(Clk)
	);

	tetrisCore dut0 (
		.Clk(Clk),
		.rst(rst),
		.keycode(keycode),
		.rowSel(rowSel),
		.blockState(blockState),
		.holdState(holdState),
		.spriteIndex(spriteIndex),
		.pieceRow(pieceRow),
		.rowBits(rowBits),
		.pause(pause),
		.state(state)
	);

	task automatic reportFailure(string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopping after the first error");
	endtask

	task automatic checkShape(logic [15:0] actual, logic [15:0] expected, string what);
		if (actual !== expected)
			reportFailure($sformatf("FAILED at time %0t: %s is %h, expected %h",
				$time, what, actual, expected));
	endtask

	task automatic checkSprite(logic [5:0] actual, logic [5:0] expected, string what);
		if (actual !== expected)
			reportFailure($sformatf("FAILED at time %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	task automatic checkRow(logic [4:0] actual, logic [4:0] expected, string what);
		if (actual !== expected)
			reportFailure($sformatf("FAILED at time %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
	endtask

	task automatic checkBits(logic [BoardCols-1:0] actual, logic [BoardCols-1:0] expected,
		string what);
		if (actual !== expected)
			reportFailure($sformatf("FAILED at time %0t: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	task automatic checkState(gameState_t actual, gameState_t expected, string what);
		if (actual !== expected)
			reportFailure($sformatf("FAILED at time %0t: %s is %s, expected %s",
				$time, what, actual.name(), expected.name()));
	endtask

	task automatic checkFlag(logic actual, logic expected, string what);
		if (actual !== expected)
			reportFailure($sformatf("FAILED at time %0t: %s is %b, expected %b",
				$time, what, actual, expected));
	endtask

	// any key code that the state machine ignores.
	function automatic logic [7:0] randomIdleKey();
		logic [7:0] key;
		key = 8'($urandom);
		while (key == KeySpace || key == KeyEsc || key == KeyPause || key == KeyTab)
			key = 8'($urandom);
		return key;
	endfunction

	// low three bits pick the piece and code 7 folds onto piece 0.
	function automatic int modelPiece();
		int idx;
		idx = int'(modelLfsr[2:0]);
		if (idx == 7)
			idx = 0;
		return idx;
	endfunction

	function automatic void stepModel();
		logic fb;
		fb = modelLfsr[15] ^ modelLfsr[13] ^ modelLfsr[12] ^ modelLfsr[10]; // taps 16 14 13 11.
		modelLfsr = {modelLfsr[14:0], fb};
	endfunction

	function automatic logic canFall(logic [15:0] shape, int row);
		int below;
		logic free;
		free = 1'b1;
		for (int r = 0; r < 4; r++)
		begin
			below = row + r + 1;
			for (int c = 0; c < 4; c++)
			begin
				if (shape[4*r + c])
				begin
					if (below >= BoardRows)
						free = 1'b0; // floor.
					else if (modelStack[below][SpawnCol + c])
						free = 1'b0;
				end
			end
		end
		return free;
	endfunction

	function automatic int landingRow(logic [15:0] shape);
		int row;
		row = 0;
		while (canFall(shape, row))
			row++;
		return row;
	endfunction

	function automatic void lockPiece(logic [15:0] shape, int row);
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < 4; c++)
				if (shape[4*r + c] && row + r < BoardRows)
					modelStack[row + r][SpawnCol + c] = 1'b1;
	endfunction

	function automatic void clearModelStack();
		for (int r = 0; r < BoardRows; r++)
			modelStack[r] = '0;
	endfunction

	// waits one clock and checks the fall rate while in Falling.
	task automatic nextCycle();
		@(posedge Clk);
		#DriveDelay;
		if (state == Falling)
		begin
			if (prevState == Falling)
				fallCycles++;
			else
				fallCycles = 0;
			checkRow(pieceRow, 5'(fallCycles / DropPeriod), "falling row");
		end
		prevState = state;
	endtask

	task automatic checkNewPiece();
		int idx;
		idx = modelPiece();
		curShape = pieceShape[idx];
		checkShape(blockState, curShape, "new piece shape");
		checkSprite(spriteIndex, spriteBase[idx], "new piece sprite");
		stepModel();
	endtask

	task automatic checkStack();
		for (int r = 0; r < BoardRows; r++)
		begin
			rowSel = 5'(r);
			#1;
			checkBits(rowBits, modelStack[r], $sformatf("stack row %0d", r));
		end
	endtask

	// lets the piece fall until the core reports the landing.
	task automatic landPiece();
		int expRow;
		int lastFall;
		checkState(state, Falling, "state before landing");
		expRow = landingRow(curShape);
		lastFall = fallCycles;
		while (state == Falling)
		begin
			lastFall = fallCycles;
			nextCycle();
		end
		checkState(state, Bottom, "state after landing");
		checkRow(pieceRow, 5'(expRow), "landing row");
		if (lastFall + 1 != (expRow + 1) * DropPeriod)
			reportFailure($sformatf("FAILED at time %0t: landing after %0d cycles, expected %0d",
				$time, lastFall + 1, (expRow + 1) * DropPeriod));
		lockPiece(curShape, expRow);
		checkStack();
	endtask

	task automatic resumeFromPause();
		keycode = KeyPause;
		nextCycle();
		checkState(state, PauseState1, "state after bottom");
		checkFlag(pause, 1'b1, "pause in PauseState1");
		repeat (PauseHoldCycles)
		begin
			nextCycle();
			checkState(state, PauseState1, "state while P is held");
		end
		keycode = idleKey;
		nextCycle();
		checkState(state, PauseState2, "state after P release");
		checkFlag(pause, 1'b1, "pause in PauseState2");
		nextCycle();
		checkState(state, PauseState2, "state with no key");
		keycode = KeyPause;
		nextCycle();
		checkState(state, Drop, "state after second P");
		checkFlag(pause, 1'b0, "pause in Drop");
		keycode = idleKey;
		nextCycle();
		checkState(state, Falling, "state after Drop");
		checkNewPiece();
	endtask

	task automatic testResetAndStart();
		checkState(state, Wait, "state after reset");
		checkFlag(pause, 1'b1, "pause after reset");
		checkShape(blockState, 16'h0000, "blockState after reset");
		checkShape(holdState, 16'h0000, "holdState after reset");
		keycode = randomIdleKey();
		nextCycle();
		nextCycle();
		checkState(state, Wait, "state with a non-command key");
		keycode = KeySpace;
		nextCycle();
		checkState(state, Drop, "state after space");
		keycode = idleKey;
		nextCycle();
		checkState(state, Falling, "state after Drop");
		checkFlag(pause, 1'b0, "pause in Falling");
		checkNewPiece();
	endtask

	task automatic testFallRate();
		logic [4:0] startRow;
		startRow = 5'd0; // a new piece enters at the top row.
		checkRow(pieceRow, startRow, "row at spawn");
		for (int k = 1; k <= 3; k++)
		begin
			repeat (DropPeriod)
				nextCycle();
			checkState(state, Falling, "state while falling");
			checkRow(pieceRow, startRow + 5'(k), "row after a drop period");
		end
	endtask

	task automatic testLandingAndPause();
		landPiece();
		resumeFromPause();
	endtask

	task automatic testStacking();
		landPiece(); // landing row comes from the model stack.
		resumeFromPause();
	endtask

	task automatic testHold();
		logic [15:0] priorBlock;
		priorBlock = curShape;
		keycode = KeyTab;
		nextCycle();
		checkState(state, Hold, "state after tab");
		keycode = idleKey;
		nextCycle();
		checkState(state, Drop, "state after Hold");
		checkShape(holdState, priorBlock, "held piece");
		nextCycle();
		checkState(state, Falling, "state after hold draw");
		checkNewPiece();
		keycode = KeyTab; // second hold on the same landing is refused.
		repeat (3)
		begin
			nextCycle();
			checkState(state, Falling, "state after second tab");
		end
		checkShape(holdState, priorBlock, "held piece after second tab");
		keycode = idleKey;
		landPiece();
		resumeFromPause();
		priorBlock = curShape;
		keycode = KeyTab;
		nextCycle();
		checkState(state, Hold, "state after tab past a landing");
		keycode = idleKey;
		nextCycle();
		checkState(state, Drop, "state after second Hold");
		checkShape(holdState, priorBlock, "held piece past a landing");
		nextCycle();
		checkState(state, Falling, "state after second hold draw");
		checkNewPiece();
	endtask

	task automatic testEscape();
		keycode = KeyEsc;
		nextCycle();
		checkState(state, Wait, "state after escape");
		checkFlag(pause, 1'b1, "pause after escape");
		keycode = idleKey;
		nextCycle();
		checkState(state, Wait, "state one cycle after escape");
		clearModelStack();
		checkStack();
	endtask

	initial
	begin
		void'($urandom(RandomSeed));
		idleKey = randomIdleKey();
		rst = 1'b1;
		keycode = idleKey;
		rowSel = '0;
		modelLfsr = LfsrSeed;
		curShape = '0;
		prevState = Wait;
		fallCycles = 0;
		clearModelStack();
		repeat (2)
			@(posedge Clk);
		#DriveDelay;
		rst = 1'b0;
		testResetAndStart();
		testFallRate();
		testLandingAndPause();
		testStacking();
		testHold();
		testEscape();
		$display("Result: PASSED");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * ClkPeriod);
		reportFailure($sformatf("Timeout: the tests did not finish within %0d clock cycles.",
			WatchdogCycles));
	end

endmodule

/* vlog.f */
verilog/tetrisPkg.sv
verilog/pieceGenerator.sv
verilog/gameControl.sv
verilog/playfield.sv
verilog/tetrisCore.sv
testbench/tbClock.sv
testbench/tetrisTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f vlog.f --top-module tetrisTb -Mdir obj_dir -o tetrisSim \
	> build.log 2>&1 \
	&& ./obj_dir/tetrisSim > sim.log 2>&1 \
	|| echo "build or simulation stopped with an error, see build.log and sim.log"
grep -q "Result: PASSED" sim.log 2> /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
